//--- common/id_settings.svh
`ifndef ID_SETTINGS_SVH
`define ID_SETTINGS_SVH

// datapath widths
`define DATA_W      32
`define REG_ADDR_W  5
`define REG_COUNT   32

// jal writes its return address here
`define LINK_REG    5'd31

// return address is pc plus this, past the delay slot
`define LINK_OFFSET 32'd8

`endif

//--- common/id_pkg.sv
package id_pkg;

    `include "id_settings.svh"

    typedef logic [`DATA_W-1:0]     word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // major opcodes, 0 is the R type
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_JAL   = 6'h03,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDIU = 6'h09,
        OP_SLTI  = 6'h0a,
        OP_SLTIU = 6'h0b,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_XORI  = 6'h0e,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    // R type function field
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        ALU_NONE, ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_NOR,
        ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {SRC1_RS, SRC1_PC, SRC1_SA} src1_sel_e;

    // link means the constant return offset
    typedef enum logic [1:0] {SRC2_RT, SRC2_SIMM, SRC2_LINK, SRC2_ZIMM} src2_sel_e;

    typedef enum logic [2:0] {BR_NONE, BR_BEQ, BR_BNE, BR_J, BR_JAL, BR_JR} br_kind_e;

endpackage

//--- common/operand_if.sv
`timescale 1ns/1ns
`include "id_settings.svh"

// source register numbers out of decode, forwarded values back
interface operand_if;

    logic [`REG_ADDR_W-1:0] rs_addr;
    logic [`REG_ADDR_W-1:0] rt_addr;
    logic [`DATA_W-1:0]     rs_data;  // after forwarding
    logic [`DATA_W-1:0]     rt_data;

    modport decoder  (output rs_addr, output rt_addr);
    modport operands (input rs_addr, input rt_addr, output rs_data, output rt_data);
    modport branch   (input rs_data, input rt_data);

endinterface

//--- design/stage_latch.sv
`timescale 1ns/1ns

module stage_latch (
    input  logic          clk,
    input  logic          rst,
    input  logic          stall_if,
    input  logic          stall_id,
    input  logic          if_valid,
    input  id_pkg::word_t if_pc,
    input  id_pkg::word_t inst_rdata,
    output logic          id_valid,
    output id_pkg::word_t id_pc,
    output id_pkg::word_t id_inst
);
    import id_pkg::*;

    logic  slot_valid;
    word_t slot_pc;
    logic  buf_flag;   // set while buf_inst holds the stalled word
    word_t buf_inst;

    always_ff @(posedge clk) begin
        if (rst) begin
            slot_valid <= 1'b0;
            buf_flag   <= 1'b0;
        end else if (!stall_id) begin
            slot_valid <= if_valid;     // normal advance
            buf_flag   <= 1'b0;
        end else if (!stall_if) begin
            slot_valid <= 1'b0;         // bubble into decode
            buf_flag   <= 1'b0;
        end else if (!buf_flag) begin
            buf_flag   <= 1'b1;         // first held cycle, sram word is captured below
        end
    end

    // payload, no reset
    always_ff @(posedge clk) begin
        if (!stall_id) begin
            slot_pc <= if_pc;
        end
        if (stall_id && stall_if && !buf_flag) begin
            buf_inst <= inst_rdata;     // sram moves on, keep our word
        end
    end

    assign id_valid = slot_valid;
    assign id_pc    = slot_pc;
    assign id_inst  = !slot_valid ? '0 : (buf_flag ? buf_inst : inst_rdata);

endmodule

//--- operand/reg_file.sv
`timescale 1ns/1ns
`include "id_settings.svh"

module reg_file (
    input  logic              clk,
    input  id_pkg::reg_addr_t raddr1,
    input  id_pkg::reg_addr_t raddr2,
    input  logic              we,
    input  id_pkg::reg_addr_t waddr,
    input  id_pkg::word_t     wdata,
    output id_pkg::word_t     rdata1,
    output id_pkg::word_t     rdata2
);
    import id_pkg::*;

    word_t regs [`REG_COUNT];

    // writeback port, $0 never stored
    always_ff @(posedge clk) begin
        if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // async reads, same-cycle writes come in through forwarding
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- operand/operand_forward.sv
`timescale 1ns/1ns

module operand_forward (
    input  logic              ex_rf_we,
    input  id_pkg::reg_addr_t ex_rf_waddr,
    input  id_pkg::word_t     ex_rf_wdata,
    input  logic              mem_rf_we,
    input  id_pkg::reg_addr_t mem_rf_waddr,
    input  id_pkg::word_t     mem_rf_wdata,
    input  logic              wb_rf_we,
    input  id_pkg::reg_addr_t wb_rf_waddr,
    input  id_pkg::word_t     wb_rf_wdata,
    input  logic              ex_mem_read,   // load sitting in execute
    input  logic              uses_rt,
    input  id_pkg::word_t     rf_rdata1,
    input  id_pkg::word_t     rf_rdata2,
    operand_if.operands       ops,
    output id_pkg::reg_addr_t rf_raddr1,
    output id_pkg::reg_addr_t rf_raddr2,
    output logic              load_stall
);
    import id_pkg::*;

    logic hit_rs;
    logic hit_rt;

    // youngest producer wins, $0 is never forwarded
    function automatic word_t pick(input reg_addr_t addr, input word_t rf_val);
        if (addr == '0) return '0;
        if (ex_rf_we && (ex_rf_waddr == addr)) return ex_rf_wdata;
        if (mem_rf_we && (mem_rf_waddr == addr)) return mem_rf_wdata;
        if (wb_rf_we && (wb_rf_waddr == addr)) return wb_rf_wdata;
        return rf_val;
    endfunction

    assign rf_raddr1 = ops.rs_addr;
    assign rf_raddr2 = ops.rt_addr;

    always_comb begin
        ops.rs_data = pick(ops.rs_addr, rf_rdata1);
        ops.rt_data = pick(ops.rt_addr, rf_rdata2);
    end

    // load data only shows up after mem, ex value is not the real result
    assign hit_rs     = (ex_rf_waddr == ops.rs_addr);
    assign hit_rt     = uses_rt && (ex_rf_waddr == ops.rt_addr);
    assign load_stall = ex_mem_read && ex_rf_we && (ex_rf_waddr != '0) && (hit_rs || hit_rt);

endmodule

//--- decode/inst_decoder.sv
`timescale 1ns/1ns
`include "id_settings.svh"

module inst_decoder (
    input  logic              id_valid,
    input  id_pkg::word_t     id_inst,
    operand_if.decoder        ops,
    output logic              uses_rt,      // rt is a real source
    output id_pkg::alu_op_e   alu_op,
    output id_pkg::src1_sel_e src1_sel,
    output id_pkg::src2_sel_e src2_sel,
    output logic              mem_en,
    output logic              mem_we,
    output logic              rf_we,
    output id_pkg::reg_addr_t rf_waddr,
    output logic              rf_from_mem,  // writeback from load data
    output id_pkg::br_kind_e  br_kind
);
    import id_pkg::*;

    opcode_e   opcode;
    funct_e    funct;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;

    assign opcode = opcode_e'(id_inst[31:26]);
    assign rs     = id_inst[25:21];
    assign rt     = id_inst[20:16];
    assign rd     = id_inst[15:11];
    assign funct  = funct_e'(id_inst[5:0]);  // shamt sits in [10:6], execute picks it up

    assign ops.rs_addr = rs;
    assign ops.rt_addr = rt;

    always_comb begin
        alu_op      = ALU_NONE;
        src1_sel    = SRC1_RS;
        src2_sel    = SRC2_RT;
        mem_en      = 1'b0;
        mem_we      = 1'b0;
        rf_we       = 1'b0;
        rf_waddr    = rt;
        rf_from_mem = 1'b0;
        uses_rt     = 1'b0;
        br_kind     = BR_NONE;
        if (id_valid) begin
            case (opcode)
                OP_RTYPE: begin
                    rf_waddr = rd;
                    rf_we    = 1'b1;
                    uses_rt  = 1'b1;
                    case (funct)
                        FN_ADDU: alu_op = ALU_ADD;
                        FN_SUBU: alu_op = ALU_SUB;
                        FN_AND:  alu_op = ALU_AND;
                        FN_OR:   alu_op = ALU_OR;
                        FN_XOR:  alu_op = ALU_XOR;
                        FN_NOR:  alu_op = ALU_NOR;
                        FN_SLT:  alu_op = ALU_SLT;
                        FN_SLTU: alu_op = ALU_SLTU;
                        FN_SLL, FN_SRL, FN_SRA: begin
                            src1_sel = SRC1_SA;    // shift by shamt, rt is the value
                            alu_op   = (funct == FN_SLL) ? ALU_SLL :
                                       (funct == FN_SRL) ? ALU_SRL : ALU_SRA;
                        end
                        FN_JR: begin
                            rf_we   = 1'b0;
                            uses_rt = 1'b0;
                            br_kind = BR_JR;
                        end
                        default: begin             // unknown funct, no effect
                            rf_we   = 1'b0;
                            uses_rt = 1'b0;
                        end
                    endcase
                end
                OP_ADDIU, OP_SLTI, OP_SLTIU, OP_LUI: begin
                    rf_we    = 1'b1;
                    src2_sel = SRC2_SIMM;
                    alu_op   = (opcode == OP_ADDIU) ? ALU_ADD :
                               (opcode == OP_SLTI)  ? ALU_SLT :
                               (opcode == OP_SLTIU) ? ALU_SLTU : ALU_LUI;
                end
                OP_ANDI, OP_ORI, OP_XORI: begin
                    rf_we    = 1'b1;
                    src2_sel = SRC2_ZIMM;         // logic ops zero-extend
                    alu_op   = (opcode == OP_ANDI) ? ALU_AND :
                               (opcode == OP_ORI)  ? ALU_OR : ALU_XOR;
                end
                OP_LW: begin
                    alu_op      = ALU_ADD;        // base + offset
                    src2_sel    = SRC2_SIMM;
                    mem_en      = 1'b1;
                    rf_we       = 1'b1;
                    rf_from_mem = 1'b1;
                end
                OP_SW: begin
                    alu_op   = ALU_ADD;
                    src2_sel = SRC2_SIMM;
                    mem_en   = 1'b1;
                    mem_we   = 1'b1;
                    uses_rt  = 1'b1;              // store data
                end
                OP_BEQ, OP_BNE: begin
                    uses_rt = 1'b1;
                    br_kind = (opcode == OP_BEQ) ? BR_BEQ : BR_BNE;
                end
                OP_J: br_kind = BR_J;
                OP_JAL: begin
                    alu_op   = ALU_ADD;           // pc + link offset into $31
                    src1_sel = SRC1_PC;
                    src2_sel = SRC2_LINK;
                    rf_we    = 1'b1;
                    rf_waddr = `LINK_REG;
                    br_kind  = BR_JAL;
                end
                default: ;                        // not a kept instruction
            endcase
        end
    end

endmodule

//--- decode/branch_unit.sv
`timescale 1ns/1ns

module branch_unit (
    input  id_pkg::word_t    id_pc,
    input  id_pkg::word_t    id_inst,
    input  id_pkg::br_kind_e br_kind,
    operand_if.branch        ops,
    output logic             br_taken,
    output id_pkg::word_t    br_target
);
    import id_pkg::*;

    word_t pc_plus_4;
    word_t br_offset;   // sign-extended word offset
    word_t jump_addr;   // pseudo-direct j/jal target
    logic  rs_eq_rt;

    assign pc_plus_4 = id_pc + 32'd4;
    assign br_offset = {{14{id_inst[15]}}, id_inst[15:0], 2'b00};
    assign jump_addr = {pc_plus_4[31:28], id_inst[25:0], 2'b00};
    assign rs_eq_rt  = (ops.rs_data == ops.rt_data);  // forwarded values

    always_comb begin
        br_taken  = 1'b0;
        br_target = '0;
        case (br_kind)
            BR_BEQ: begin
                br_taken  = rs_eq_rt;
                br_target = pc_plus_4 + br_offset;
            end
            BR_BNE: begin
                br_taken  = !rs_eq_rt;
                br_target = pc_plus_4 + br_offset;
            end
            BR_J, BR_JAL: begin
                br_taken  = 1'b1;
                br_target = jump_addr;
            end
            BR_JR: begin
                br_taken  = 1'b1;
                br_target = ops.rs_data;      // register target
            end
            default: ;
        endcase
    end

endmodule

//--- design/id_stage.sv
`timescale 1ns/1ns

module id_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               stall_if,
    input  logic               stall_id,
    input  logic               if_valid,
    input  id_pkg::word_t      if_pc,
    input  id_pkg::word_t      inst_rdata,   // sram data, one cycle after pc capture
    input  logic               ex_mem_read,
    input  logic               ex_rf_we,
    input  id_pkg::reg_addr_t  ex_rf_waddr,
    input  id_pkg::word_t      ex_rf_wdata,
    input  logic               mem_rf_we,
    input  id_pkg::reg_addr_t  mem_rf_waddr,
    input  id_pkg::word_t      mem_rf_wdata,
    input  logic               wb_rf_we,
    input  id_pkg::reg_addr_t  wb_rf_waddr,
    input  id_pkg::word_t      wb_rf_wdata,
    output logic               load_stall,
    output logic               id_valid,
    output id_pkg::word_t      id_pc,
    output id_pkg::word_t      id_inst,
    output id_pkg::alu_op_e    alu_op,
    output id_pkg::src1_sel_e  src1_sel,
    output id_pkg::src2_sel_e  src2_sel,
    output logic               mem_en,
    output logic               mem_we,
    output logic               rf_we,
    output id_pkg::reg_addr_t  rf_waddr,
    output logic               rf_from_mem,
    output id_pkg::word_t      rdata1,
    output id_pkg::word_t      rdata2,
    output logic               br_taken,
    output id_pkg::word_t      br_target
);
    import id_pkg::*;

    reg_addr_t rf_raddr1;
    reg_addr_t rf_raddr2;
    word_t     rf_rdata1;  // raw array reads
    word_t     rf_rdata2;
    logic      uses_rt;
    br_kind_e  br_kind;

    operand_if ops ();

    stage_latch u_stage_latch (
        .clk(clk), .rst(rst), .stall_if(stall_if), .stall_id(stall_id),
        .if_valid(if_valid), .if_pc(if_pc), .inst_rdata(inst_rdata),
        .id_valid(id_valid), .id_pc(id_pc), .id_inst(id_inst)
    );

    reg_file u_reg_file (
        .clk(clk), .raddr1(rf_raddr1), .raddr2(rf_raddr2),
        .we(wb_rf_we), .waddr(wb_rf_waddr), .wdata(wb_rf_wdata),
        .rdata1(rf_rdata1), .rdata2(rf_rdata2)
    );

    operand_forward u_operand_forward (
        .ex_rf_we(ex_rf_we), .ex_rf_waddr(ex_rf_waddr), .ex_rf_wdata(ex_rf_wdata),
        .mem_rf_we(mem_rf_we), .mem_rf_waddr(mem_rf_waddr), .mem_rf_wdata(mem_rf_wdata),
        .wb_rf_we(wb_rf_we), .wb_rf_waddr(wb_rf_waddr), .wb_rf_wdata(wb_rf_wdata),
        .ex_mem_read(ex_mem_read), .uses_rt(uses_rt),
        .rf_rdata1(rf_rdata1), .rf_rdata2(rf_rdata2), .ops(ops.operands),
        .rf_raddr1(rf_raddr1), .rf_raddr2(rf_raddr2), .load_stall(load_stall)
    );

    inst_decoder u_inst_decoder (
        .id_valid(id_valid), .id_inst(id_inst), .ops(ops.decoder),
        .uses_rt(uses_rt), .alu_op(alu_op), .src1_sel(src1_sel), .src2_sel(src2_sel),
        .mem_en(mem_en), .mem_we(mem_we), .rf_we(rf_we), .rf_waddr(rf_waddr),
        .rf_from_mem(rf_from_mem), .br_kind(br_kind)
    );

    branch_unit u_branch_unit (
        .id_pc(id_pc), .id_inst(id_inst), .br_kind(br_kind), .ops(ops.branch),
        .br_taken(br_taken), .br_target(br_target)
    );

    // forwarded operands go on to execute
    assign rdata1 = ops.rs_data;
    assign rdata2 = ops.rt_data;

endmodule

//--- bench/id_properties.sv
`timescale 1ns/1ns

module id_properties (
    input logic              clk,
    input logic              rst,
    input logic              id_valid,
    input logic              rf_we,
    input logic              mem_en,
    input logic              br_taken,
    input logic              load_stall,
    input logic              ex_mem_read,
    input id_pkg::src2_sel_e src2_sel,
    input id_pkg::reg_addr_t rf_waddr
);
    import id_pkg::*;

    // empty slot must not act
    empty_slot_quiet: assert property (@(posedge clk) disable iff (rst)
        !id_valid |-> !(rf_we || mem_en || br_taken))
        else $error("control active while id_valid is low");

    stall_needs_load: assert property (@(posedge clk) disable iff (rst)
        load_stall |-> ex_mem_read)
        else $error("load_stall without a load in execute");

    // link writes go to a real register
    link_dest_nonzero: assert property (@(posedge clk) disable iff (rst)
        (rf_we && src2_sel == SRC2_LINK) |-> (rf_waddr != '0))
        else $error("link write aimed at register 0");

endmodule

bind id_stage id_properties u_id_properties (
    .clk(clk), .rst(rst), .id_valid(id_valid), .rf_we(rf_we), .mem_en(mem_en),
    .br_taken(br_taken), .load_stall(load_stall), .ex_mem_read(ex_mem_read),
    .src2_sel(src2_sel), .rf_waddr(rf_waddr)
);

//--- bench/tb_id_stage.sv
`timescale 1ns/1ns

module tb_id_stage;
    import id_pkg::*;

    // one table row, enum fields kept as raw codes
    typedef struct {
        logic      s_if;
        logic      s_id;
        word_t     pc;
        word_t     inst;
        logic      ex_we;
        logic      ex_mr;
        reg_addr_t ex_a;
        word_t     ex_d;
        logic      mem_we_f;
        reg_addr_t mem_a;
        word_t     mem_d;
        logic      wb_we;
        reg_addr_t wb_a;
        word_t     wb_d;
        logic      valid;
        word_t     xpc;      // pc expected in the slot
        word_t     xinst;    // word expected on id_inst
        logic [3:0] alu;
        logic [1:0] s1;
        logic [1:0] s2;
        logic      we;
        reg_addr_t wa;
        logic      men;
        logic      mwe;
        logic      rfm;
        word_t     d1;
        word_t     d2;
        logic      ls;
        logic      bt;
        word_t     tgt;
    } row_t;

    logic clk;
    logic rst;
    logic stall_if;
    logic stall_id;
    logic if_valid;
    word_t if_pc;
    word_t inst_rdata;
    logic ex_mem_read;
    logic ex_rf_we;
    reg_addr_t ex_rf_waddr;
    word_t ex_rf_wdata;
    logic mem_rf_we;
    reg_addr_t mem_rf_waddr;
    word_t mem_rf_wdata;
    logic wb_rf_we;
    reg_addr_t wb_rf_waddr;
    word_t wb_rf_wdata;
    logic load_stall;
    logic id_valid;
    word_t id_pc;
    word_t id_inst;
    alu_op_e alu_op;
    src1_sel_e src1_sel;
    src2_sel_e src2_sel;
    logic mem_en;
    logic mem_we;
    logic rf_we;
    reg_addr_t rf_waddr;
    logic rf_from_mem;
    word_t rdata1;
    word_t rdata2;
    logic br_taken;
    word_t br_target;

    row_t  rows[$];
    row_t  cur;
    word_t pre[8];       // register preload values, pre[0] stays zero
    integer seed;
    integer errors;
    integer checks;

    id_stage DUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic word_t enc_r(reg_addr_t rs, reg_addr_t rt, reg_addr_t rd,
                                    logic [4:0] sa, funct_e fn);
        return {6'h00, rs, rt, rd, sa, fn};
    endfunction

    function automatic word_t enc_i(opcode_e op, reg_addr_t rs, reg_addr_t rt,
                                    logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t enc_j(opcode_e op, logic [25:0] idx);
        return {op, idx};
    endfunction

    // new row, no forwarding unless fwd follows
    task automatic stim(input logic s_if, input logic s_id, input word_t pc,
                        input word_t inst);
        cur.s_if  = s_if;
        cur.s_id  = s_id;
        cur.pc    = pc;
        cur.inst  = inst;
        cur.valid = !(s_id && !s_if);   // only the bubble case empties the slot
        cur.xpc   = pc;
        cur.xinst = cur.valid ? inst : '0;   // empty slot shows a zero word
        fwd(0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    endtask

    task automatic fwd(input logic ex_we, input logic ex_mr, input reg_addr_t ex_a,
                       input word_t ex_d, input logic m_we, input reg_addr_t m_a,
                       input word_t m_d, input logic w_we, input reg_addr_t w_a,
                       input word_t w_d);
        cur.ex_we    = ex_we;
        cur.ex_mr    = ex_mr;
        cur.ex_a     = ex_a;
        cur.ex_d     = ex_d;
        cur.mem_we_f = m_we;
        cur.mem_a    = m_a;
        cur.mem_d    = m_d;
        cur.wb_we    = w_we;
        cur.wb_a     = w_a;
        cur.wb_d     = w_d;
    endtask

    task automatic ctl(input alu_op_e alu, input src1_sel_e s1, input src2_sel_e s2,
                       input logic we, input reg_addr_t wa, input logic men,
                       input logic mwe, input logic rfm);
        cur.alu = alu;
        cur.s1  = s1;
        cur.s2  = s2;
        cur.we  = we;
        cur.wa  = wa;
        cur.men = men;
        cur.mwe = mwe;
        cur.rfm = rfm;
    endtask

    // expected data side, closes the row
    task automatic dat(input word_t d1, input word_t d2, input logic ls, input logic bt,
                       input word_t tgt);
        cur.d1  = d1;
        cur.d2  = d2;
        cur.ls  = ls;
        cur.bt  = bt;
        cur.tgt = tgt;
        rows.push_back(cur);
    endtask

    task automatic build_table();
        // plain reads and $0
        stim(0, 0, 32'h0040_0000, enc_r(1, 2, 3, 0, FN_ADDU));
        ctl(ALU_ADD, SRC1_RS, SRC2_RT, 1, 3, 0, 0, 0);
        dat(pre[1], pre[2], 0, 0, 0);
        stim(0, 0, 32'h0040_0004, enc_i(OP_ORI, 0, 4, 16'h1234));
        ctl(ALU_OR, SRC1_RS, SRC2_ZIMM, 1, 4, 0, 0, 0);
        dat(0, pre[4], 0, 0, 0);
        // $6 on every stage, then drop one source at a time
        stim(0, 0, 32'h0040_0008, enc_r(6, 6, 1, 0, FN_ADDU));
        fwd(1, 0, 6, 32'haaaa_0001, 1, 6, 32'hbbbb_0002, 1, 6, 32'hcccc_0003);
        ctl(ALU_ADD, SRC1_RS, SRC2_RT, 1, 1, 0, 0, 0);
        dat(32'haaaa_0001, 32'haaaa_0001, 0, 0, 0);
        stim(0, 0, 32'h0040_000c, enc_r(6, 6, 1, 0, FN_ADDU));
        fwd(0, 0, 0, 0, 1, 6, 32'hbbbb_0002, 1, 6, 32'hcccc_0003);
        ctl(ALU_ADD, SRC1_RS, SRC2_RT, 1, 1, 0, 0, 0);
        dat(32'hbbbb_0002, 32'hbbbb_0002, 0, 0, 0);
        stim(0, 0, 32'h0040_0010, enc_r(6, 6, 1, 0, FN_ADDU));
        fwd(0, 0, 0, 0, 0, 0, 0, 1, 6, 32'hcccc_0003);
        ctl(ALU_ADD, SRC1_RS, SRC2_RT, 1, 1, 0, 0, 0);
        dat(32'hcccc_0003, 32'hcccc_0003, 0, 0, 0);
        stim(0, 0, 32'h0040_0014, enc_r(6, 6, 1, 0, FN_ADDU));   // now from the array
        ctl(ALU_ADD, SRC1_RS, SRC2_RT, 1, 1, 0, 0, 0);
        dat(32'hcccc_0003, 32'hcccc_0003, 0, 0, 0);
        // load-use cases
        stim(0, 0, 32'h0040_0018, enc_r(1, 2, 3, 0, FN_ADDU));
        fwd(1, 1, 2, 32'h0bad_f00d, 0, 0, 0, 0, 0, 0);
        ctl(ALU_ADD, SRC1_RS, SRC2_RT, 1, 3, 0, 0, 0);
        dat(pre[1], 32'h0bad_f00d, 1, 0, 0);
        stim(0, 0, 32'h0040_001c, enc_i(OP_ORI, 1, 2, 16'h0005));  // rt is the dest here
        fwd(1, 1, 2, 32'h0bad_f00d, 0, 0, 0, 0, 0, 0);
        ctl(ALU_OR, SRC1_RS, SRC2_ZIMM, 1, 2, 0, 0, 0);
        dat(pre[1], 32'h0bad_f00d, 0, 0, 0);
        stim(0, 0, 32'h0040_0020, enc_r(0, 0, 3, 0, FN_ADDU));
        fwd(1, 1, 0, 32'h0bad_f00d, 0, 0, 0, 0, 0, 0);
        ctl(ALU_ADD, SRC1_RS, SRC2_RT, 1, 3, 0, 0, 0);
        dat(0, 0, 0, 0, 0);
        stim(0, 0, 32'h0040_0024, enc_i(OP_LW, 1, 4, 16'h0008));
        fwd(1, 1, 1, 32'h0bad_f00d, 0, 0, 0, 0, 0, 0);
        ctl(ALU_ADD, SRC1_RS, SRC2_SIMM, 1, 4, 1, 0, 1);
        dat(32'h0bad_f00d, pre[4], 1, 0, 0);
        // remaining control decode
        stim(0, 0, 32'h0040_0028, enc_r(0, 2, 3, 4, FN_SLL));
        ctl(ALU_SLL, SRC1_SA, SRC2_RT, 1, 3, 0, 0, 0);
        dat(0, pre[2], 0, 0, 0);
        stim(0, 0, 32'h0040_002c, enc_i(OP_LUI, 0, 7, 16'habcd));
        ctl(ALU_LUI, SRC1_RS, SRC2_SIMM, 1, 7, 0, 0, 0);
        dat(0, pre[7], 0, 0, 0);
        stim(0, 0, 32'h0040_0030, enc_i(OP_SLTI, 1, 5, 16'hfffd));
        ctl(ALU_SLT, SRC1_RS, SRC2_SIMM, 1, 5, 0, 0, 0);
        dat(pre[1], pre[5], 0, 0, 0);
        stim(0, 0, 32'h0040_0034, enc_i(OP_SW, 1, 2, 16'h0004));
        ctl(ALU_ADD, SRC1_RS, SRC2_SIMM, 0, 2, 1, 1, 0);
        dat(pre[1], pre[2], 0, 0, 0);
        stim(0, 0, 32'h2000_0300, enc_j(OP_JAL, 26'h000_0abc));
        ctl(ALU_ADD, SRC1_PC, SRC2_LINK, 1, 31, 0, 0, 0);
        dat(0, 0, 0, 1, 32'h2000_2af0);
        // branches and jumps
        stim(0, 0, 32'h0040_0100, enc_i(OP_BEQ, 1, 1, 16'hfffc));
        ctl(ALU_NONE, SRC1_RS, SRC2_RT, 0, 1, 0, 0, 0);
        dat(pre[1], pre[1], 0, 1, 32'h0040_00f4);
        stim(0, 0, 32'h0040_0100, enc_i(OP_BEQ, 1, 2, 16'hfffc));
        ctl(ALU_NONE, SRC1_RS, SRC2_RT, 0, 2, 0, 0, 0);
        dat(pre[1], pre[2], 0, 0, 32'h0040_00f4);
        stim(0, 0, 32'h0040_0100, enc_i(OP_BNE, 1, 2, 16'h0010));
        ctl(ALU_NONE, SRC1_RS, SRC2_RT, 0, 2, 0, 0, 0);
        dat(pre[1], pre[2], 0, 1, 32'h0040_0144);
        stim(0, 0, 32'h0040_0100, enc_i(OP_BNE, 1, 1, 16'h0010));  // equal, falls through
        ctl(ALU_NONE, SRC1_RS, SRC2_RT, 0, 1, 0, 0, 0);
        dat(pre[1], pre[1], 0, 0, 32'h0040_0144);
        stim(0, 0, 32'h1000_0200, enc_j(OP_J, 26'h000_1234));
        ctl(ALU_NONE, SRC1_RS, SRC2_RT, 0, 0, 0, 0, 0);
        dat(0, 0, 0, 1, 32'h1000_48d0);
        stim(0, 0, 32'h0040_0200, enc_r(3, 0, 0, 0, FN_JR));
        fwd(1, 0, 3, 32'h0040_2000, 0, 0, 0, 0, 0, 0);
        ctl(ALU_NONE, SRC1_RS, SRC2_RT, 0, 0, 0, 0, 0);
        dat(32'h0040_2000, 0, 0, 1, 32'h0040_2000);
        // bubble, then hold with sram moving, then release
        stim(0, 1, 32'h0040_0500, enc_r(1, 2, 3, 0, FN_ADDU));
        ctl(ALU_NONE, SRC1_RS, SRC2_RT, 0, 0, 0, 0, 0);
        dat(0, 0, 0, 0, 0);
        stim(0, 0, 32'h0040_0500, enc_r(1, 2, 3, 0, FN_ADDU));
        ctl(ALU_ADD, SRC1_RS, SRC2_RT, 1, 3, 0, 0, 0);
        dat(pre[1], pre[2], 0, 0, 0);
        stim(1, 1, 32'h0040_0504, enc_i(OP_LUI, 0, 7, 16'hdead));   // buffered addu wins
        cur.xpc   = 32'h0040_0500;                                  // held slot keeps its pc
        cur.xinst = enc_r(1, 2, 3, 0, FN_ADDU);
        ctl(ALU_ADD, SRC1_RS, SRC2_RT, 1, 3, 0, 0, 0);
        dat(pre[1], pre[2], 0, 0, 0);
        stim(0, 0, 32'h0040_0500, enc_r(1, 2, 3, 0, FN_ADDU));
        ctl(ALU_ADD, SRC1_RS, SRC2_RT, 1, 3, 0, 0, 0);
        dat(pre[1], pre[2], 0, 0, 0);
    endtask

    task automatic report(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("** Error @%0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_alu(input alu_op_e got, input alu_op_e exp, input string what);
        report(what, 32'(got), 32'(exp));
    endtask

    task automatic check_src1(input src1_sel_e got, input src1_sel_e exp, input string what);
        report(what, 32'(got), 32'(exp));
    endtask

    task automatic check_src2(input src2_sel_e got, input src2_sel_e exp, input string what);
        report(what, 32'(got), 32'(exp));
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        report(what, got, exp);
    endtask

    task automatic check_addr(input reg_addr_t got, input reg_addr_t exp, input string what);
        report(what, 32'(got), 32'(exp));
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        report(what, 32'(got), 32'(exp));
    endtask

    task automatic check_row(input row_t r, input integer n);
        string tag;
        tag = $sformatf("row %0d", n);
        check_bit(id_valid, r.valid, {tag, " id_valid"});
        if (r.valid) begin
            check_word(id_pc, r.xpc, {tag, " id_pc"});   // pc of an empty slot is stale
        end
        check_word(id_inst, r.xinst, {tag, " id_inst"});
        check_alu(alu_op, alu_op_e'(r.alu), {tag, " alu_op"});
        check_src1(src1_sel, src1_sel_e'(r.s1), {tag, " src1_sel"});
        check_src2(src2_sel, src2_sel_e'(r.s2), {tag, " src2_sel"});
        check_bit(rf_we, r.we, {tag, " rf_we"});
        check_addr(rf_waddr, r.wa, {tag, " rf_waddr"});
        check_bit(mem_en, r.men, {tag, " mem_en"});
        check_bit(mem_we, r.mwe, {tag, " mem_we"});
        check_bit(rf_from_mem, r.rfm, {tag, " rf_from_mem"});
        check_word(rdata1, r.d1, {tag, " rdata1"});
        check_word(rdata2, r.d2, {tag, " rdata2"});
        check_bit(load_stall, r.ls, {tag, " load_stall"});
        check_bit(br_taken, r.bt, {tag, " br_taken"});
        check_word(br_target, r.tgt, {tag, " br_target"});
    endtask

    // ends a hung run, budget scales with the table
    initial begin
        #1;
        #(rows.size() * 20 + 500);
        $display("timeout: the row loop did not finish in time");
        $display("Checks failed");
        $finish;
    end

    initial begin
        stall_if     = 1'b0;
        stall_id     = 1'b0;
        if_valid     = 1'b0;
        if_pc        = '0;
        inst_rdata   = '0;
        ex_mem_read  = 1'b0;
        ex_rf_we     = 1'b0;
        ex_rf_waddr  = '0;
        ex_rf_wdata  = '0;
        mem_rf_we    = 1'b0;
        mem_rf_waddr = '0;
        mem_rf_wdata = '0;
        wb_rf_we     = 1'b0;
        wb_rf_waddr  = '0;
        wb_rf_wdata  = '0;
        rst          = 1'b1;
        seed         = 81;
        errors       = 0;
        checks       = 0;
        pre[0]       = '0;
        for (int i = 1; i < 8; i++) pre[i] = $random(seed);
        build_table();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        for (int i = 1; i < 8; i++) begin      // preload through writeback
            @(posedge clk);
            wb_rf_we    <= 1'b1;
            wb_rf_waddr <= reg_addr_t'(i);
            wb_rf_wdata <= pre[i];
        end
        @(posedge clk);
        wb_rf_we <= 1'b0;
        foreach (rows[i]) begin
            @(posedge clk);                     // pc into fetch side
            stall_if <= rows[i].s_if;
            stall_id <= rows[i].s_id;
            if_valid <= 1'b1;
            if_pc    <= rows[i].pc;
            @(posedge clk);                     // captured, sram word follows
            inst_rdata   <= rows[i].inst;
            ex_rf_we     <= rows[i].ex_we;
            ex_mem_read  <= rows[i].ex_mr;
            ex_rf_waddr  <= rows[i].ex_a;
            ex_rf_wdata  <= rows[i].ex_d;
            mem_rf_we    <= rows[i].mem_we_f;
            mem_rf_waddr <= rows[i].mem_a;
            mem_rf_wdata <= rows[i].mem_d;
            wb_rf_we     <= rows[i].wb_we;
            wb_rf_waddr  <= rows[i].wb_a;
            wb_rf_wdata  <= rows[i].wb_d;
            @(negedge clk);                     // outputs settled
            check_row(rows[i], i);
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- id_stage.f
+incdir+common
common/id_pkg.sv
common/operand_if.sv
design/stage_latch.sv
operand/reg_file.sv
operand/operand_forward.sv
decode/inst_decoder.sv
decode/branch_unit.sv
design/id_stage.sv
bench/id_properties.sv
bench/tb_id_stage.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_id_stage
FLIST     ?= id_stage.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "All checks passed"

clean:
	rm -rf $(OBJ_DIR)
